//--- rtl/trap_pkg.sv
// Trap unit shared definitions
package trap_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////

  // address width of the core
  localparam int XLEN = 32;

  // cause: bit 5 marks an interrupt, bits 4..0 code or irq index
  localparam int CAUSE_W = 6;

  ////////////////////////////////////////////////////////////////////////////
  // cause codes and vector offsets
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [CAUSE_W-1:0] CAUSE_ILLINSN = 6'b0_00010;
  localparam logic [CAUSE_W-1:0] CAUSE_ECALL   = 6'b0_01000;

  // byte offsets from the vector table base
  localparam logic [XLEN-1:0] OFS_ILLINSN = 32'h0000_0084;
  localparam logic [XLEN-1:0] OFS_ECALL   = 32'h0000_0088;

  ////////////////////////////////////////////////////////////////////////////
  // enums
  ////////////////////////////////////////////////////////////////////////////

  // exception controller states
  typedef enum logic [1:0] {
    IDLE,
    WAIT_CTRL,
    IN_ISR
  } exc_state_e;

  // source of the trap pc
  typedef enum logic [2:0] {
    PC_NONE,
    PC_ILLINSN,
    PC_ECALL,
    PC_IRQ,
    PC_ERET
  } pc_sel_e;

endpackage

//--- rtl/trap_if.sv
// Trap decision bus
`timescale 1ns/10ps

interface trap_if
  import trap_pkg::*;
();

  // pc source for the trap target
  pc_sel_e              pc_sel;
  // cause to save into mcause
  logic [CAUSE_W-1:0]   cause;
  // interrupt index for the vectored target
  logic [CAUSE_W-2:0]   vec_idx;
  // one cycle pulse on trap acceptance
  logic                 save;
  // one cycle pulse on trap return
  logic                 eret;

  // driven by the exception controller
  modport ctrl (
    output pc_sel,
    output cause,
    output vec_idx,
    output save,
    output eret
  );

  // read by csr block and pc generator
  modport sink (
    input pc_sel,
    input cause,
    input vec_idx,
    input save,
    input eret
  );

endinterface

//--- rtl/irq_sync.sv
// Interrupt line synchronizer
`timescale 1ns/10ps

module irq_sync #(
  parameter int NUM_IRQ = 32
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic [NUM_IRQ-1:0] irq_i,
  input  logic               mie_i,
  output logic [NUM_IRQ-1:0] irq_o
);

  ////////////////////////////////////////////////////////////////////////////
  // two flop synchronizer
  ////////////////////////////////////////////////////////////////////////////

  logic [NUM_IRQ-1:0] meta_q;
  logic [NUM_IRQ-1:0] sync_q;
  logic [NUM_IRQ-1:0] mask;

  // replicate enable over all lines
  assign mask = {NUM_IRQ{mie_i}};

  // first stage may go metastable
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      meta_q <= '0;
    end
    else
    begin
      meta_q <= irq_i;
    end
  end

  // second stage, masked on the way in
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sync_q <= '0;
    end
    else
    begin
      sync_q <= meta_q & mask;
    end
  end

  // mask again so a line disabled this cycle
  // is already hidden from the controller
  assign irq_o = sync_q & mask;

endmodule

//--- rtl/exc_controller.sv
// Exception controller
`timescale 1ns/10ps

module exc_controller
  import trap_pkg::*;
#(
  parameter int NUM_IRQ = 32
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic [NUM_IRQ-1:0] irq_i,
  input  logic               illegal_i,
  input  logic               ecall_i,
  input  logic               eret_i,
  input  logic               ack_i,
  output logic               req_o,
  trap_if.ctrl               tif
);

  localparam int IDX_W = CAUSE_W - 1;

  exc_state_e          state_q;
  exc_state_e          state_d;
  logic                req_int;
  logic                bypass;
  logic [CAUSE_W-1:0]  cause_c;
  logic [CAUSE_W-1:0]  cause_q;
  pc_sel_e             pc_sel_c;
  pc_sel_e             pc_sel_q;

  // any pending source
  assign req_int = illegal_i | ecall_i | (|irq_i);

  ////////////////////////////////////////////////////////////////////////////
  // cause priority
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    cause_c  = '0;
    pc_sel_c = PC_NONE;
    // walk down so the lowest pending line wins
    for (int i = NUM_IRQ - 1; i >= 0; i--)
    begin
      if (irq_i[i])
      begin
        cause_c  = {1'b1, IDX_W'(i)};
        pc_sel_c = PC_IRQ;
      end
    end
    if (ecall_i)
    begin
      cause_c  = CAUSE_ECALL;
      pc_sel_c = PC_ECALL;
    end
    // illegal insn overrides everything
    if (illegal_i)
    begin
      cause_c  = CAUSE_ILLINSN;
      pc_sel_c = PC_ILLINSN;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // hold and bypass
  ////////////////////////////////////////////////////////////////////////////

  // first request cycle, decision not yet registered
  assign bypass = (state_q == IDLE) && req_int;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cause_q  <= '0;
      pc_sel_q <= PC_NONE;
    end
    else if (bypass)
    begin
      cause_q  <= cause_c;
      pc_sel_q <= pc_sel_c;
    end
  end

  always_comb
  begin
    tif.cause  = bypass ? cause_c : cause_q;
    tif.pc_sel = bypass ? pc_sel_c : pc_sel_q;
    // return address takes over in the eret cycle
    if (state_q == IN_ISR && eret_i)
    begin
      tif.pc_sel = PC_ERET;
    end
  end

  // vector index only meaningful for interrupts
  assign tif.vec_idx = tif.cause[CAUSE_W-1] ? tif.cause[IDX_W-1:0] : '0;

  ////////////////////////////////////////////////////////////////////////////
  // req/ack/eret FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d  = state_q;
    req_o    = 1'b0;
    tif.save = 1'b0;
    tif.eret = 1'b0;
    unique case (state_q)
      IDLE:
      begin
        req_o = req_int;
        if (req_int)
        begin
          state_d = WAIT_CTRL;
        end
      end
      WAIT_CTRL:
      begin
        req_o = 1'b1;
        // acceptance cycle
        if (ack_i)
        begin
          tif.save = 1'b1;
          state_d  = IN_ISR;
        end
      end
      IN_ISR:
      begin
        // new sources ignored until return
        if (eret_i)
        begin
          tif.eret = 1'b1;
          state_d  = IDLE;
        end
      end
      default:
      begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // assertions
  ////////////////////////////////////////////////////////////////////////////

  // csr and pc gen only see a save while waiting on ack
  a_save_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
    tif.save |-> (state_q == WAIT_CTRL))
    else $error("save outside WAIT_CTRL");

  // request only drops after the pipeline took it
  a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(req_o) |-> $past(ack_i))
    else $error("req_o fell without ack_i");

  // pc source and cause type agree, eret excluded
  a_irq_cause: assert property (@(posedge clk) disable iff (!rst_n)
    (tif.pc_sel != PC_ERET) |-> ((tif.pc_sel == PC_IRQ) == tif.cause[CAUSE_W-1]))
    else $error("pc_sel and cause bit 5 disagree");

endmodule

//--- rtl/trap_csr.sv
// Trap CSR registers
`timescale 1ns/10ps

module trap_csr
  import trap_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic               mie_we_i,
  input  logic               mie_wdata_i,
  trap_if.sink               tif,
  output logic               mie_o,
  output logic [CAUSE_W-1:0] mcause_o
);

  logic               mie_q;
  logic [CAUSE_W-1:0] mcause_q;

  ////////////////////////////////////////////////////////////////////////////
  // interrupt enable
  ////////////////////////////////////////////////////////////////////////////

  // trap entry and return take precedence over a software write
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      mie_q <= 1'b0;
    end
    else if (tif.save)
    begin
      // no nesting, interrupts off inside the handler
      mie_q <= 1'b0;
    end
    else if (tif.eret)
    begin
      mie_q <= 1'b1;
    end
    else if (mie_we_i)
    begin
      mie_q <= mie_wdata_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // saved cause
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      mcause_q <= '0;
    end
    else if (tif.save)
    begin
      mcause_q <= tif.cause;
    end
  end

  assign mie_o    = mie_q;
  assign mcause_o = mcause_q;

  // entry and return belong to different controller states
  a_save_eret_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(tif.save && tif.eret))
    else $error("save and eret in the same cycle");

endmodule

//--- rtl/trap_pc_gen.sv
// Trap target PC generator
`timescale 1ns/10ps

module trap_pc_gen
  import trap_pkg::*;
#(
  parameter logic [XLEN-1:0] TRAP_BASE = 32'h0000_1000
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic [XLEN-1:0] pc_i,
  trap_if.sink            tif,
  output logic [XLEN-1:0] target_pc_o,
  output logic [XLEN-1:0] mepc_o
);

  logic [XLEN-1:0] mepc_q;
  logic [XLEN-1:0] irq_target;

  // one word per interrupt line in the vector table
  assign irq_target = TRAP_BASE + (XLEN'(tif.vec_idx) << 2);

  ////////////////////////////////////////////////////////////////////////////
  // target select
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    unique case (tif.pc_sel)
      PC_ILLINSN: target_pc_o = TRAP_BASE + OFS_ILLINSN;
      PC_ECALL:   target_pc_o = TRAP_BASE + OFS_ECALL;
      PC_IRQ:     target_pc_o = irq_target;
      // return straight to the saved pc
      PC_ERET:    target_pc_o = mepc_q;
      default:    target_pc_o = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // exception pc
  ////////////////////////////////////////////////////////////////////////////

  // pc of the trapped instruction, taken on acceptance
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      mepc_q <= '0;
    end
    else if (tif.save)
    begin
      mepc_q <= pc_i;
    end
  end

  assign mepc_o = mepc_q;

endmodule

//--- rtl/trap_unit.sv
// Trap handling unit
`timescale 1ns/10ps

module trap_unit
  import trap_pkg::*;
#(
  parameter int              NUM_IRQ   = 32,
  parameter logic [XLEN-1:0] TRAP_BASE = 32'h0000_1000
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic [NUM_IRQ-1:0] irq_i,
  input  logic               illegal_i,
  input  logic               ecall_i,
  input  logic               eret_i,
  input  logic               ack_i,
  input  logic [XLEN-1:0]    pc_i,
  input  logic               mie_we_i,
  input  logic               mie_wdata_i,
  output logic               req_o,
  output logic [XLEN-1:0]    target_pc_o,
  output logic [CAUSE_W-1:0] cause_o,
  output logic [CAUSE_W-1:0] mcause_o,
  output logic [XLEN-1:0]    mepc_o,
  output logic               mie_o
);

  logic [NUM_IRQ-1:0] irq_sync;

  // decision from controller to csr and pc gen
  trap_if trap_bus ();

  // mie fed back to mask the lines
  irq_sync #(.NUM_IRQ(NUM_IRQ)) i_irq_sync (
    .clk   (clk),
    .rst_n (rst_n),
    .irq_i (irq_i),
    .mie_i (mie_o),
    .irq_o (irq_sync)
  );

  exc_controller #(.NUM_IRQ(NUM_IRQ)) i_exc_controller (
    .clk       (clk),
    .rst_n     (rst_n),
    .irq_i     (irq_sync),
    .illegal_i (illegal_i),
    .ecall_i   (ecall_i),
    .eret_i    (eret_i),
    .ack_i     (ack_i),
    .req_o     (req_o),
    .tif       (trap_bus.ctrl)
  );

  trap_csr i_trap_csr (
    .clk         (clk),
    .rst_n       (rst_n),
    .mie_we_i    (mie_we_i),
    .mie_wdata_i (mie_wdata_i),
    .tif         (trap_bus.sink),
    .mie_o       (mie_o),
    .mcause_o    (mcause_o)
  );

  trap_pc_gen #(.TRAP_BASE(TRAP_BASE)) i_trap_pc_gen (
    .clk         (clk),
    .rst_n       (rst_n),
    .pc_i        (pc_i),
    .tif         (trap_bus.sink),
    .target_pc_o (target_pc_o),
    .mepc_o      (mepc_o)
  );

  // live cause, bypassed in the first request cycle
  assign cause_o = trap_bus.cause;

endmodule

//--- test/trap_unit_tb.sv
// Trap unit testbench
`timescale 1ns/10ps

module trap_unit_tb
  import trap_pkg::*;
();

  localparam int              NUM_IRQ      = 32;
  localparam logic [XLEN-1:0] TRAP_BASE    = 32'h0000_2000;
  localparam int              NUM_ROWS     = 10;
  localparam int              RESET_CYCLES = 10;
  localparam int              REQ_WAIT     = 8;
  localparam int              CYCLE_LIMIT  = NUM_ROWS * 40 + RESET_CYCLES;

  // one stimulus row with its expected response
  typedef struct packed {
    logic [NUM_IRQ-1:0] irq;
    logic               ill;
    logic               ecall;
    logic               mie;
    logic               inj;
    logic [XLEN-1:0]    pc;
    logic               exp_req;
    logic [CAUSE_W-1:0] exp_cause;
    logic [XLEN-1:0]    exp_target;
  } row_t;

  logic               clk;
  logic               rst_n;
  logic [NUM_IRQ-1:0] irq_i;
  logic               illegal_i;
  logic               ecall_i;
  logic               eret_i;
  logic               ack_i;
  logic [XLEN-1:0]    pc_i;
  logic               mie_we_i;
  logic               mie_wdata_i;
  logic               req_o;
  logic [XLEN-1:0]    target_pc_o;
  logic [CAUSE_W-1:0] cause_o;
  logic [CAUSE_W-1:0] mcause_o;
  logic [XLEN-1:0]    mepc_o;
  logic               mie_o;

  row_t        rows [NUM_ROWS];
  int          n_rows = 0;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  logic [31:0] lfsr   = 32'd72180;

  trap_unit #(.NUM_IRQ(NUM_IRQ), .TRAP_BASE(TRAP_BASE)) i_trap_unit (
    .clk         (clk),
    .rst_n       (rst_n),
    .irq_i       (irq_i),
    .illegal_i   (illegal_i),
    .ecall_i     (ecall_i),
    .eret_i      (eret_i),
    .ack_i       (ack_i),
    .pc_i        (pc_i),
    .mie_we_i    (mie_we_i),
    .mie_wdata_i (mie_wdata_i),
    .req_o       (req_o),
    .target_pc_o (target_pc_o),
    .cause_o     (cause_o),
    .mcause_o    (mcause_o),
    .mepc_o      (mepc_o),
    .mie_o       (mie_o)
  );

  // 8 ns period
  always
  begin
    #4 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // random ack delay and expected values
  ////////////////////////////////////////////////////////////////////////////

  // galois lfsr over x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0])
    begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    else
    begin
      return s >> 1;
    end
  endfunction

  // one lfsr step per bit taken
  function automatic int rand_bits(input int n);
    int val;
    val = 0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_step(lfsr);
      val  = (val << 1) | int'(lfsr[0]);
    end
    return val;
  endfunction

  // illegal before ecall before the lowest enabled line
  function automatic logic [CAUSE_W-1:0] priority_cause(input row_t rw);
    logic [CAUSE_W-1:0] c;
    c = '0;
    if (rw.ill)
    begin
      c = CAUSE_ILLINSN;
    end
    else if (rw.ecall)
    begin
      c = CAUSE_ECALL;
    end
    else if (rw.mie)
    begin
      for (int i = 0; i < NUM_IRQ; i++)
      begin
        if (rw.irq[i] && !c[CAUSE_W-1])
        begin
          c = {1'b1, 5'(i)};
        end
      end
    end
    return c;
  endfunction

  // exceptions at fixed offsets and interrupts one word apart
  function automatic logic [XLEN-1:0] vector_target(input row_t rw);
    if (rw.ill)
    begin
      return TRAP_BASE + OFS_ILLINSN;
    end
    else if (rw.ecall)
    begin
      return TRAP_BASE + OFS_ECALL;
    end
    return TRAP_BASE + 32'(rw.exp_cause[4:0]) * 32'd4;
  endfunction

  task automatic add_row(input logic [NUM_IRQ-1:0] irq, input logic ill, input logic ecall,
                         input logic mie, input logic inj, input logic [XLEN-1:0] pc);
    row_t rw;
    rw            = '0;
    rw.irq        = irq;
    rw.ill        = ill;
    rw.ecall      = ecall;
    rw.mie        = mie;
    rw.inj        = inj;
    rw.pc         = pc;
    rw.exp_req    = ill | ecall | (mie & (|irq));
    rw.exp_cause  = priority_cause(rw);
    rw.exp_target = vector_target(rw);
    rows[n_rows]  = rw;
    n_rows++;
  endtask

  // irq, illegal, ecall, mie, inject illegal during back-pressure, pc
  task automatic build_table();
    add_row(32'h0000_0000, 1'b1, 1'b0, 1'b1, 1'b0, 32'h0000_0100);
    add_row(32'h0000_0000, 1'b0, 1'b1, 1'b1, 1'b1, 32'h0000_0104);
    add_row(32'h0000_0000, 1'b1, 1'b1, 1'b1, 1'b0, 32'h0000_0108);
    add_row(32'h0000_0020, 1'b0, 1'b0, 1'b1, 1'b1, 32'h0000_010c);
    add_row(32'h0000_0001, 1'b0, 1'b0, 1'b1, 1'b0, 32'h0000_0110);
    add_row(32'h8000_1080, 1'b0, 1'b0, 1'b1, 1'b1, 32'h0000_0114);
    add_row(32'h8000_0000, 1'b0, 1'b0, 1'b1, 1'b0, 32'h0000_0118);
    // masked line, no request expected
    add_row(32'h0000_0008, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_011c);
    add_row(32'h0000_0200, 1'b0, 1'b1, 1'b1, 1'b0, 32'h0000_0120);
    add_row(32'h0010_0004, 1'b0, 1'b0, 1'b1, 1'b1, 32'h0000_0124);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // checks and run control
  ////////////////////////////////////////////////////////////////////////////

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic report_and_finish();
    $display("errors: %0d in %0d checks", errors, checks);
    if (errors == 0)
    begin
      $display("TEST RESULT: PASS");
    end
    else
    begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  endtask

  // sampled on falling edges with a bound
  task automatic wait_req(output logic seen);
    int n;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < REQ_WAIT)
    begin
      @(negedge clk);
      seen = req_o;
      n++;
    end
  endtask

  task automatic run_row(input int r, output logic ok);
    row_t rw;
    logic seen;
    int   delay;
    rw = rows[r];
    ok = 1'b1;
    // program the interrupt enable
    mie_we_i    = 1'b1;
    mie_wdata_i = rw.mie;
    @(negedge clk);
    mie_we_i = 1'b0;
    check("mie_o", 32'(rw.mie), 32'(mie_o));
    pc_i      = rw.pc;
    irq_i     = rw.irq;
    illegal_i = rw.ill;
    ecall_i   = rw.ecall;
    if (!rw.exp_req)
    begin
      // disabled line must stay invisible
      repeat (10)
      begin
        @(negedge clk);
        check("req_o", 32'd0, 32'(req_o));
      end
      irq_i = '0;
      // flush the synchronizer
      repeat (3)
      begin
        @(negedge clk);
      end
      return;
    end
    if (rw.ill || rw.ecall)
    begin
      // exceptions reach the outputs in the same cycle
      #2;
      check("req_o", 32'd1, 32'(req_o));
      check("cause_o", 32'(rw.exp_cause), 32'(cause_o));
      check("target_pc_o", rw.exp_target, target_pc_o);
    end
    wait_req(seen);
    if (!seen)
    begin
      $display("req_o never rose in row %0d", r);
      errors++;
      ok = 1'b0;
      return;
    end
    check("cause_o", 32'(rw.exp_cause), 32'(cause_o));
    check("target_pc_o", rw.exp_target, target_pc_o);
    // at least one cycle so ack lands in WAIT_CTRL
    delay = 1 + rand_bits(3);
    for (int k = 0; k < delay; k++)
    begin
      @(negedge clk);
      check("req_o", 32'd1, 32'(req_o));
      check("cause_o", 32'(rw.exp_cause), 32'(cause_o));
      check("target_pc_o", rw.exp_target, target_pc_o);
      // higher priority source once the decision is registered
      if (rw.inj && k == 0)
      begin
        illegal_i = 1'b1;
      end
    end
    ack_i = 1'b1;
    @(negedge clk);
    ack_i = 1'b0;
    // one cycle after acceptance
    check("req_o", 32'd0, 32'(req_o));
    check("mcause_o", 32'(rw.exp_cause), 32'(mcause_o));
    check("mepc_o", rw.pc, mepc_o);
    check("mie_o", 32'd0, 32'(mie_o));
    // sources still held while the handler runs
    repeat (3)
    begin
      @(negedge clk);
      check("req_o", 32'd0, 32'(req_o));
    end
    irq_i     = '0;
    illegal_i = 1'b0;
    ecall_i   = 1'b0;
    @(negedge clk);
    eret_i = 1'b1;
    // return target settled by mid phase
    #2;
    check("target_pc_o", rw.pc, target_pc_o);
    @(negedge clk);
    eret_i = 1'b0;
    check("mie_o", 32'd1, 32'(mie_o));
    check("req_o", 32'd0, 32'(req_o));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    logic ok;
    clk         = 1'b0;
    rst_n       = 1'b0;
    irq_i       = '0;
    illegal_i   = 1'b0;
    ecall_i     = 1'b0;
    eret_i      = 1'b0;
    ack_i       = 1'b0;
    pc_i        = '0;
    mie_we_i    = 1'b0;
    mie_wdata_i = 1'b0;
    build_table();
    repeat (RESET_CYCLES)
    begin
      @(negedge clk);
    end
    rst_n = 1'b1;
    @(negedge clk);
    // reset state
    check("req_o", 32'd0, 32'(req_o));
    check("mcause_o", 32'd0, 32'(mcause_o));
    check("mepc_o", 32'd0, mepc_o);
    check("mie_o", 32'd0, 32'(mie_o));
    ok = 1'b1;
    for (int r = 0; r < n_rows && ok; r++)
    begin
      run_row(r, ok);
    end
    report_and_finish();
  end

  initial
  begin
    while (cycles < CYCLE_LIMIT)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout, run did not end within %0d cycles", CYCLE_LIMIT);
    errors++;
    report_and_finish();
  end

endmodule

//--- verilog.f
rtl/trap_pkg.sv
rtl/trap_if.sv
rtl/irq_sync.sv
rtl/exc_controller.sv
rtl/trap_csr.sv
rtl/trap_pc_gen.sv
rtl/trap_unit.sv
test/trap_unit_tb.sv

//--- Makefile
TOOL     = verilator
TOP      = trap_unit_tb
FILELIST = verilog.f
FLAGS    = --binary --timing --assert -j 0
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
